//--- files.f
muldiv_op_pkg.sv
muldiv_fsm_pkg.sv
muldiv_decode.sv
int_mul_iterative.sv
int_div_iterative.sv
muldiv_execute.sv
muldiv_result.sv
muldiv_unit.sv
tb_muldiv_unit.sv

//--- int_div_iterative.sv
/*
  restoring magnitude divider, one quotient bit per cycle,
  remainder in the upper half of raw and quotient in the lower half
*/
`default_nettype none

module int_div_iterative (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             start_val,
  output logic                             start_rdy,
  input  logic [muldiv_op_pkg::XLEN-1:0]   mag_a,
  input  logic [muldiv_op_pkg::XLEN-1:0]   mag_b,
  output logic                             done_val,
  input  logic                             done_rdy,
  output logic [muldiv_op_pkg::RLEN-1:0]   raw
);

  muldiv_fsm_pkg::iter_state_e     state;
  logic [muldiv_fsm_pkg::CNT_W-1:0] cnt;

  logic [muldiv_op_pkg::XLEN-1:0]  divisor;
  // partial remainder
  logic [muldiv_op_pkg::XLEN-1:0]  rem;
  // dividend bits shift out the top, quotient bits fill from the bottom
  logic [muldiv_op_pkg::XLEN-1:0]  quo;

  logic [muldiv_op_pkg::XLEN:0]    trial;
  logic [muldiv_op_pkg::XLEN+1:0]  diff;
  logic                            fits;
  logic                            start_go;

  // ------------------------------
  // control
  // ------------------------------

  assign start_rdy = (state == muldiv_fsm_pkg::IDLE);
  assign done_val  = (state == muldiv_fsm_pkg::DONE);
  assign start_go  = start_val & start_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= muldiv_fsm_pkg::IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        muldiv_fsm_pkg::IDLE: begin
          if (start_go) begin
            state <= muldiv_fsm_pkg::CALC;
            cnt   <= muldiv_fsm_pkg::CNT_W'(muldiv_fsm_pkg::ITER_COUNT - 1);
          end
        end
        muldiv_fsm_pkg::CALC: begin
          if (cnt == '0) begin
            state <= muldiv_fsm_pkg::DONE;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        muldiv_fsm_pkg::DONE: begin
          if (done_rdy) begin
            state <= muldiv_fsm_pkg::IDLE;
          end
        end
        default: begin
          state <= muldiv_fsm_pkg::IDLE;
        end
      endcase
    end
  end

  // ------------------------------
  // datapath
  // ------------------------------

  // shift remainder left and bring in the next dividend bit
  assign trial = {rem, quo[muldiv_op_pkg::XLEN-1]};
  // one spare bit so the borrow shows as the sign
  assign diff  = {1'b0, trial} - {2'b00, divisor};
  // zero divisor never borrows, giving all-ones quotient
  assign fits  = ~diff[muldiv_op_pkg::XLEN+1];

  always_ff @(posedge clk) begin
    if (start_go) begin
      divisor <= mag_b;
      rem     <= '0;
      quo     <= mag_a;
    end else if (state == muldiv_fsm_pkg::CALC) begin
      // trial < 2*divisor, so the kept remainder fits in XLEN bits
      rem <= fits ? diff[muldiv_op_pkg::XLEN-1:0] : trial[muldiv_op_pkg::XLEN-1:0];
      quo <= {quo[muldiv_op_pkg::XLEN-2:0], fits};
    end
  end

  assign raw = {rem, quo};

endmodule

`default_nettype wire

//--- int_mul_iterative.sv
/*
  shift-and-add magnitude multiplier, one multiplier bit per cycle,
  with its own idle/calc/done control
*/
`default_nettype none

module int_mul_iterative (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             start_val,
  output logic                             start_rdy,
  input  logic [muldiv_op_pkg::XLEN-1:0]   mag_a,
  input  logic [muldiv_op_pkg::XLEN-1:0]   mag_b,
  output logic                             done_val,
  input  logic                             done_rdy,
  output logic [muldiv_op_pkg::RLEN-1:0]   raw
);

  muldiv_fsm_pkg::iter_state_e     state;
  logic [muldiv_fsm_pkg::CNT_W-1:0] cnt;

  // multiplicand shifts left across the full product width
  logic [muldiv_op_pkg::RLEN-1:0]  mcand;
  // multiplier shifts right, low bit picks the add
  logic [muldiv_op_pkg::XLEN-1:0]  mplier;
  logic [muldiv_op_pkg::RLEN-1:0]  acc;

  logic                            start_go;
  logic                            last_step;

  // ------------------------------
  // control
  // ------------------------------

  assign start_rdy = (state == muldiv_fsm_pkg::IDLE);
  assign done_val  = (state == muldiv_fsm_pkg::DONE);
  assign start_go  = start_val & start_rdy;
  assign last_step = (cnt == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= muldiv_fsm_pkg::IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        muldiv_fsm_pkg::IDLE: begin
          if (start_go) begin
            state <= muldiv_fsm_pkg::CALC;
            cnt   <= muldiv_fsm_pkg::CNT_W'(muldiv_fsm_pkg::ITER_COUNT - 1);
          end
        end
        muldiv_fsm_pkg::CALC: begin
          // exactly ITER_COUNT cycles here
          if (last_step) begin
            state <= muldiv_fsm_pkg::DONE;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        muldiv_fsm_pkg::DONE: begin
          if (done_rdy) begin
            state <= muldiv_fsm_pkg::IDLE;
          end
        end
        default: begin
          state <= muldiv_fsm_pkg::IDLE;
        end
      endcase
    end
  end

  // ------------------------------
  // datapath
  // ------------------------------

  always_ff @(posedge clk) begin
    if (start_go) begin
      // load operands, clear the running sum
      mcand  <= {{muldiv_op_pkg::XLEN{1'b0}}, mag_a};
      mplier <= mag_b;
      acc    <= '0;
    end else if (state == muldiv_fsm_pkg::CALC) begin
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // accumulator is the product once in done
  assign raw = acc;

endmodule

`default_nettype wire

//--- muldiv_cases.txt
// op a b expected, all hex; op 0 mul, 1 mulu, 2 div, 3 divu
// expected is the full product, or remainder:quotient for a divide
0 00000003 00000005 000000000000000f
0 fffffff9 00000006 ffffffffffffffd6
0 fffffff8 fffffff7 0000000000000048
0 00000000 ffffffff 0000000000000000
0 80000000 80000000 4000000000000000
0 7fffffff ffffffff ffffffff80000001
1 ffffffff ffffffff fffffffe00000001
1 12345678 00000010 0000000123456780
2 00000064 00000007 000000020000000e
2 ffffff9c 00000007 fffffffefffffff2
2 00000064 fffffff9 00000002fffffff2
2 ffffff9c fffffff9 fffffffe0000000e
2 80000000 ffffffff 0000000080000000
2 ffffff9c 00000000 ffffff9cffffffff
3 ffffffff 00000010 0000000f0fffffff
3 80000001 00000000 80000001ffffffff

//--- muldiv_decode.sv
/*
  decode stage: request register, operand magnitudes and result sign flags
*/
`default_nettype none

module muldiv_decode (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             req_val,
  output logic                             req_rdy,
  input  muldiv_op_pkg::muldiv_op_e        req_op,
  input  logic [muldiv_op_pkg::XLEN-1:0]   req_a,
  input  logic [muldiv_op_pkg::XLEN-1:0]   req_b,
  output logic                             dec_val,
  input  logic                             dec_rdy,
  output logic                             dec_is_div,
  output logic [muldiv_op_pkg::XLEN-1:0]   dec_mag_a,
  output logic [muldiv_op_pkg::XLEN-1:0]   dec_mag_b,
  output logic                             dec_lo_neg,
  output logic                             dec_hi_neg
);

  logic                           is_signed;
  logic                           is_div;
  logic                           a_neg;
  logic                           b_neg;
  logic [muldiv_op_pkg::XLEN-1:0] mag_a;
  logic [muldiv_op_pkg::XLEN-1:0] mag_b;
  logic                           lo_neg;
  logic                           hi_neg;
  logic                           req_go;

  // ------------------------------
  // operand decode
  // ------------------------------

  assign is_signed = (req_op == muldiv_op_pkg::MUL) || (req_op == muldiv_op_pkg::DIV);
  assign is_div    = (req_op == muldiv_op_pkg::DIV) || (req_op == muldiv_op_pkg::DIVU);

  // sign bits only count for signed opcodes
  assign a_neg = is_signed & req_a[muldiv_op_pkg::XLEN-1];
  assign b_neg = is_signed & req_b[muldiv_op_pkg::XLEN-1];

  // two's complement magnitude, most negative value maps onto itself
  assign mag_a = a_neg ? (~req_a + 1'b1) : req_a;
  assign mag_b = b_neg ? (~req_b + 1'b1) : req_b;

  // quotient sign follows product rule, but not for a zero divisor
  // so the all-ones quotient survives
  assign lo_neg = (a_neg ^ b_neg) & (~is_div | (|req_b));
  // remainder takes dividend sign, unused for multiply
  assign hi_neg = is_div & a_neg;

  // ------------------------------
  // one-item stage register
  // ------------------------------

  // free when empty or being drained this cycle
  assign req_rdy = ~dec_val | dec_rdy;
  assign req_go  = req_val & req_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      dec_val <= 1'b0;
    end else if (req_go) begin
      dec_val <= 1'b1;
    end else if (dec_rdy) begin
      dec_val <= 1'b0;
    end
  end

  // payload only moves on an accepted request
  always_ff @(posedge clk) begin
    if (req_go) begin
      dec_is_div <= is_div;
      dec_mag_a  <= mag_a;
      dec_mag_b  <= mag_b;
      dec_lo_neg <= lo_neg;
      dec_hi_neg <= hi_neg;
    end
  end

endmodule

`default_nettype wire

//--- muldiv_execute.sv
/*
  execute stage: owns one item, dispatches it to the multiplier or the
  divider and returns the raw magnitude result with its sign flags
*/
`default_nettype none

module muldiv_execute (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             dec_val,
  output logic                             dec_rdy,
  input  logic                             dec_is_div,
  input  logic [muldiv_op_pkg::XLEN-1:0]   dec_mag_a,
  input  logic [muldiv_op_pkg::XLEN-1:0]   dec_mag_b,
  input  logic                             dec_lo_neg,
  input  logic                             dec_hi_neg,
  output logic                             exe_val,
  input  logic                             exe_rdy,
  output logic [muldiv_op_pkg::RLEN-1:0]   exe_raw,
  output logic                             exe_lo_neg,
  output logic                             exe_hi_neg,
  output logic                             exe_is_div
);

  // set from dispatch until the raw result leaves
  logic                           busy;
  logic                           dispatch;

  logic                           mul_start_val;
  logic                           mul_start_rdy;
  logic                           mul_done_val;
  logic                           mul_done_rdy;
  logic [muldiv_op_pkg::RLEN-1:0] mul_raw;

  logic                           div_start_val;
  logic                           div_start_rdy;
  logic                           div_done_val;
  logic                           div_done_rdy;
  logic [muldiv_op_pkg::RLEN-1:0] div_raw;

  // ------------------------------
  // dispatch side
  // ------------------------------

  assign mul_start_val = dec_val & ~busy & ~dec_is_div;
  assign div_start_val = dec_val & ~busy & dec_is_div;
  assign dec_rdy       = ~busy & (dec_is_div ? div_start_rdy : mul_start_rdy);
  assign dispatch      = dec_val & dec_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
    end else if (dispatch) begin
      busy <= 1'b1;
    end else if (exe_val & exe_rdy) begin
      busy <= 1'b0;
    end
  end

  // kind and sign flags travel alongside the item
  always_ff @(posedge clk) begin
    if (dispatch) begin
      exe_is_div <= dec_is_div;
      exe_lo_neg <= dec_lo_neg;
      exe_hi_neg <= dec_hi_neg;
    end
  end

  // ------------------------------
  // return side
  // ------------------------------

  // only the unit that owns the item may hand back a result
  assign exe_val      = busy & (exe_is_div ? div_done_val : mul_done_val);
  assign mul_done_rdy = busy & ~exe_is_div & exe_rdy;
  assign div_done_rdy = busy & exe_is_div & exe_rdy;
  assign exe_raw      = exe_is_div ? div_raw : mul_raw;

  int_mul_iterative mul0 (
    .clk       (clk),
    .reset     (reset),
    .start_val (mul_start_val),
    .start_rdy (mul_start_rdy),
    .mag_a     (dec_mag_a),
    .mag_b     (dec_mag_b),
    .done_val  (mul_done_val),
    .done_rdy  (mul_done_rdy),
    .raw       (mul_raw)
  );

  int_div_iterative div0 (
    .clk       (clk),
    .reset     (reset),
    .start_val (div_start_val),
    .start_rdy (div_start_rdy),
    .mag_a     (dec_mag_a),
    .mag_b     (dec_mag_b),
    .done_val  (div_done_val),
    .done_rdy  (div_done_rdy),
    .raw       (div_raw)
  );

endmodule

`default_nettype wire

//--- muldiv_fsm_pkg.sv
/*
  control state enum and iteration count shared by the iterative
  multiplier and divider
*/
`default_nettype none

package muldiv_fsm_pkg;

  // ------------------------------
  // iteration control
  // ------------------------------

  // one operand bit handled per calc cycle
  localparam int ITER_COUNT = 32;
  // down counter runs ITER_COUNT-1 .. 0
  localparam int CNT_W = 5;

  // ------------------------------
  // states
  // ------------------------------

  // idle  waiting for a start transfer, start_rdy high
  // calc  one shift/add or shift/subtract step per cycle
  // done  raw result held, done_val high until taken
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    CALC = 2'd1,
    DONE = 2'd2
  } iter_state_e;

endpackage

`default_nettype wire

//--- muldiv_op_pkg.sv
/*
  opcode enum, operand and result widths for the multiply/divide unit
*/
`default_nettype none

package muldiv_op_pkg;

  // ------------------------------
  // widths
  // ------------------------------

  // operand width of the processor datapath
  localparam int XLEN = 32;
  // full result, remainder:quotient or 64-bit product
  localparam int RLEN = 2 * XLEN;
  // opcode field width
  localparam int OP_W = 2;

  // ------------------------------
  // request opcodes
  // ------------------------------

  // mul   signed a * signed b, full 64-bit product
  // mulu  unsigned a * unsigned b, full 64-bit product
  // div   signed a / signed b, remainder high and quotient low
  // divu  unsigned a / unsigned b, same layout as div
  // operand a is the multiplicand or dividend, b the multiplier or divisor
  typedef enum logic [OP_W-1:0] {
    MUL  = 2'd0,
    MULU = 2'd1,
    DIV  = 2'd2,
    DIVU = 2'd3
  } muldiv_op_e;

endpackage

`default_nettype wire

//--- muldiv_result.sv
/*
  result stage: sign correction of the raw result and the response register
*/
`default_nettype none

module muldiv_result (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             exe_val,
  output logic                             exe_rdy,
  input  logic [muldiv_op_pkg::RLEN-1:0]   exe_raw,
  input  logic                             exe_lo_neg,
  input  logic                             exe_hi_neg,
  input  logic                             exe_is_div,
  output logic                             resp_val,
  input  logic                             resp_rdy,
  output logic [muldiv_op_pkg::RLEN-1:0]   resp_result
);

  logic [muldiv_op_pkg::XLEN-1:0] raw_hi;
  logic [muldiv_op_pkg::XLEN-1:0] raw_lo;
  logic [muldiv_op_pkg::XLEN-1:0] div_hi;
  logic [muldiv_op_pkg::XLEN-1:0] div_lo;
  logic [muldiv_op_pkg::RLEN-1:0] mul_fix;
  logic [muldiv_op_pkg::RLEN-1:0] fixed;
  logic                           exe_go;

  // ------------------------------
  // sign correction
  // ------------------------------

  assign raw_hi = exe_raw[muldiv_op_pkg::RLEN-1:muldiv_op_pkg::XLEN];
  assign raw_lo = exe_raw[muldiv_op_pkg::XLEN-1:0];

  // product is negated as one 64-bit value
  assign mul_fix = exe_lo_neg ? (~exe_raw + 1'b1) : exe_raw;

  // remainder and quotient are negated on their own
  assign div_hi = exe_hi_neg ? (~raw_hi + 1'b1) : raw_hi;
  assign div_lo = exe_lo_neg ? (~raw_lo + 1'b1) : raw_lo;

  assign fixed = exe_is_div ? {div_hi, div_lo} : mul_fix;

  // ------------------------------
  // response register
  // ------------------------------

  assign exe_rdy = ~resp_val | resp_rdy;
  assign exe_go  = exe_val & exe_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      resp_val <= 1'b0;
    end else if (exe_go) begin
      resp_val <= 1'b1;
    end else if (resp_rdy) begin
      resp_val <= 1'b0;
    end
  end

  // held steady while resp_rdy is low
  always_ff @(posedge clk) begin
    if (exe_go) begin
      resp_result <= fixed;
    end
  end

endmodule

`default_nettype wire

//--- muldiv_unit.sv
/*
  multiply/divide unit top: decode, execute and result stages
*/
`default_nettype none

module muldiv_unit (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             req_val,
  output logic                             req_rdy,
  input  muldiv_op_pkg::muldiv_op_e        req_op,
  input  logic [muldiv_op_pkg::XLEN-1:0]   req_a,
  input  logic [muldiv_op_pkg::XLEN-1:0]   req_b,
  output logic                             resp_val,
  input  logic                             resp_rdy,
  output logic [muldiv_op_pkg::RLEN-1:0]   resp_result
);

  // ------------------------------
  // decode to execute
  // ------------------------------
  logic                           dec_val;
  logic                           dec_rdy;
  logic                           dec_is_div;
  logic [muldiv_op_pkg::XLEN-1:0] dec_mag_a;
  logic [muldiv_op_pkg::XLEN-1:0] dec_mag_b;
  logic                           dec_lo_neg;
  logic                           dec_hi_neg;

  // ------------------------------
  // execute to result
  // ------------------------------
  logic                           exe_val;
  logic                           exe_rdy;
  logic [muldiv_op_pkg::RLEN-1:0] exe_raw;
  logic                           exe_lo_neg;
  logic                           exe_hi_neg;
  logic                           exe_is_div;

  muldiv_decode decode0 (
    .clk        (clk),
    .reset      (reset),
    .req_val    (req_val),
    .req_rdy    (req_rdy),
    .req_op     (req_op),
    .req_a      (req_a),
    .req_b      (req_b),
    .dec_val    (dec_val),
    .dec_rdy    (dec_rdy),
    .dec_is_div (dec_is_div),
    .dec_mag_a  (dec_mag_a),
    .dec_mag_b  (dec_mag_b),
    .dec_lo_neg (dec_lo_neg),
    .dec_hi_neg (dec_hi_neg)
  );

  muldiv_execute execute0 (
    .clk        (clk),
    .reset      (reset),
    .dec_val    (dec_val),
    .dec_rdy    (dec_rdy),
    .dec_is_div (dec_is_div),
    .dec_mag_a  (dec_mag_a),
    .dec_mag_b  (dec_mag_b),
    .dec_lo_neg (dec_lo_neg),
    .dec_hi_neg (dec_hi_neg),
    .exe_val    (exe_val),
    .exe_rdy    (exe_rdy),
    .exe_raw    (exe_raw),
    .exe_lo_neg (exe_lo_neg),
    .exe_hi_neg (exe_hi_neg),
    .exe_is_div (exe_is_div)
  );

  muldiv_result result0 (
    .clk         (clk),
    .reset       (reset),
    .exe_val     (exe_val),
    .exe_rdy     (exe_rdy),
    .exe_raw     (exe_raw),
    .exe_lo_neg  (exe_lo_neg),
    .exe_hi_neg  (exe_hi_neg),
    .exe_is_div  (exe_is_div),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

endmodule

`default_nettype wire

//--- tb_muldiv_unit.sv
/*
  testbench for the multiply/divide unit: file-driven cases with random
  response back-pressure, a three-deep burst and the reset state
*/
`default_nettype none

module tb_muldiv_unit;

  localparam int MAX_CASES    = 32;
  localparam int BURST_LEN    = 3;
  // longest wait for one request at req_rdy, in cycles
  localparam int ACCEPT_LIMIT = 200;

  // one line of the cases file
  typedef struct packed {
    logic [muldiv_op_pkg::OP_W-1:0] op;
    logic [muldiv_op_pkg::XLEN-1:0] a;
    logic [muldiv_op_pkg::XLEN-1:0] b;
    logic [muldiv_op_pkg::RLEN-1:0] exp;
  } case_t;

  logic                           clk;
  logic                           reset;
  logic                           req_val;
  logic                           req_rdy;
  muldiv_op_pkg::muldiv_op_e      req_op;
  logic [muldiv_op_pkg::XLEN-1:0] req_a;
  logic [muldiv_op_pkg::XLEN-1:0] req_b;
  logic                           resp_val;
  logic                           resp_rdy;
  logic [muldiv_op_pkg::RLEN-1:0] resp_result;

  // four words per case: op, a, b, expected
  logic [muldiv_op_pkg::RLEN-1:0] case_words [0:4*MAX_CASES-1];
  case_t                          cases [0:MAX_CASES-1];

  int     n_cases;
  int     cycles;
  int     cycle_limit;
  int     tests_run;
  int     tests_bad;
  int     error_count;
  int     errs_before;
  integer seed;

  muldiv_unit dut0 (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .req_op      (req_op),
    .req_a       (req_a),
    .req_b       (req_b),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .resp_result (resp_result)
  );

  // ------------------------------
  // clock and run limit
  // ------------------------------

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("timeout after %0d cycles, responses still missing", cycles);
      $display("Checks failed");
      $finish;
    end
  end

  // ------------------------------
  // request and response tasks
  // ------------------------------

  // called on a falling edge, returns on the falling edge after the accept
  task send_req(input int idx);
    int   waited;
    logic took;
    req_op  = muldiv_op_pkg::muldiv_op_e'(cases[idx].op);
    req_a   = cases[idx].a;
    req_b   = cases[idx].b;
    req_val = 1'b1;
    took    = 1'b0;
    waited  = 0;
    while (!took && waited < ACCEPT_LIMIT) begin
      // req_rdy only moves on a rising edge and ignores req_val
      took   = req_rdy;
      waited = waited + 1;
      @(negedge clk);
    end
    if (!took) begin
      $display("request for case %0d was not accepted within %0d cycles", idx, ACCEPT_LIMIT);
      error_count = error_count + 1;
    end
  endtask

  // waits for one response, checks it is held while stalled, then takes it
  task take_resp(input int idx, input bit random_rdy, input string tag);
    logic                           taken;
    logic                           holding;
    logic [muldiv_op_pkg::RLEN-1:0] held;
    logic [31:0]                    rnd;
    int                             errs;
    taken   = 1'b0;
    holding = 1'b0;
    held    = '0;
    errs    = error_count;
    while (!taken) begin
      @(negedge clk);
      // a stalled response must not move or vanish
      if (holding && !resp_val) begin
        $display("Error at time %0t: resp_val expected 1 got %b", $time, resp_val);
        error_count = error_count + 1;
      end
      if (holding && resp_val && resp_result !== held) begin
        $display("Error at time %0t: resp_result expected %h got %h", $time, held, resp_result);
        error_count = error_count + 1;
      end
      if (random_rdy) begin
        rnd      = $random(seed);
        resp_rdy = rnd[0];
      end else begin
        resp_rdy = 1'b1;
      end
      if (resp_val && resp_rdy) begin
        // taken on the next rising edge
        taken = 1'b1;
        if (resp_result !== cases[idx].exp) begin
          $display("Error at time %0t: resp_result expected %h got %h",
                   $time, cases[idx].exp, resp_result);
          error_count = error_count + 1;
        end
      end else begin
        holding = resp_val;
        held    = resp_result;
      end
    end
    tests_run = tests_run + 1;
    if (error_count != errs) begin
      tests_bad = tests_bad + 1;
      $display("%s %0d op %0d a %h b %h: mismatch", tag, idx, cases[idx].op,
               cases[idx].a, cases[idx].b);
    end else begin
      $display("%s %0d op %0d a %h b %h: ok", tag, idx, cases[idx].op,
               cases[idx].a, cases[idx].b);
    end
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    req_val     = 1'b0;
    req_op      = muldiv_op_pkg::MUL;
    req_a       = '0;
    req_b       = '0;
    resp_rdy    = 1'b0;
    seed        = 40;
    cycles      = 0;
    tests_run   = 0;
    tests_bad   = 0;
    error_count = 0;

    $readmemh("muldiv_cases.txt", case_words);
    n_cases = 0;
    // unloaded words stay unknown and end the list
    while (n_cases < MAX_CASES && !$isunknown(case_words[4*n_cases+3])) begin
      cases[n_cases] = {case_words[4*n_cases][muldiv_op_pkg::OP_W-1:0],
                        case_words[4*n_cases+1][muldiv_op_pkg::XLEN-1:0],
                        case_words[4*n_cases+2][muldiv_op_pkg::XLEN-1:0],
                        case_words[4*n_cases+3]};
      n_cases = n_cases + 1;
    end
    cycle_limit = (n_cases + BURST_LEN) * 40 + 100;

    // two rising edges with reset high
    repeat (2) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    // reset state, before any request
    errs_before = error_count;
    if (req_rdy !== 1'b1) begin
      $display("Error at time %0t: req_rdy expected 1 got %b", $time, req_rdy);
      error_count = error_count + 1;
    end
    if (resp_val !== 1'b0) begin
      $display("Error at time %0t: resp_val expected 0 got %b", $time, resp_val);
      error_count = error_count + 1;
    end
    tests_run = tests_run + 1;
    if (error_count != errs_before) begin
      tests_bad = tests_bad + 1;
      $display("reset state: mismatch");
    end else begin
      $display("reset state: ok");
    end

    if (n_cases < BURST_LEN) begin
      $display("only %0d test cases read from muldiv_cases.txt", n_cases);
      error_count = error_count + 1;
    end else begin
      // all cases streamed in file order against random back-pressure
      fork
        begin
          for (int i = 0; i < n_cases; i++) begin
            send_req(i);
          end
          req_val = 1'b0;
        end
        begin
          for (int j = 0; j < n_cases; j++) begin
            take_resp(j, 1'b1, "case");
          end
        end
      join
      // let the last response go on the coming rising edge
      @(negedge clk);

      // ------------------------------
      // burst with the response side stalled
      // ------------------------------
      resp_rdy    = 1'b0;
      errs_before = error_count;
      for (int k = 0; k < BURST_LEN; k++) begin
        send_req(k * (n_cases / BURST_LEN));
      end
      req_val = 1'b0;
      // first item sits in the result stage, nothing taken yet
      if (resp_val !== 1'b1) begin
        $display("Error at time %0t: resp_val expected 1 got %b", $time, resp_val);
        error_count = error_count + 1;
      end
      tests_run = tests_run + 1;
      if (error_count != errs_before) begin
        tests_bad = tests_bad + 1;
        $display("burst accept with resp_rdy low: mismatch");
      end else begin
        $display("burst accept with resp_rdy low: ok");
      end
      for (int k = 0; k < BURST_LEN; k++) begin
        take_resp(k * (n_cases / BURST_LEN), 1'b0, "burst");
      end
    end

    $display("tests run %0d, tests with errors %0d, errors %0d",
             tests_run, tests_bad, error_count);
    if (tests_bad == 0 && error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
